// ==== outrun_pkg.sv ====
// Shared types for one 22-bit SDRAM bank of 16-bit words and three CPU ROM clients
package outrun_pkg;

    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] rom_data_t;

    // Client to slot, addr is the client word address zero-extended
    typedef struct packed {
        logic        cs;
        sdram_addr_t addr;
    } rom_req_t;

    typedef struct packed {
        logic      ok;
        rom_data_t data;
    } rom_rsp_t;

    // Arbiter to bank
    typedef struct packed {
        logic        rd;
        sdram_addr_t addr;
    } sdram_req_t;

    typedef struct packed {
        logic      ack;
        logic      rdy;
        rom_data_t data_read;
    } sdram_rsp_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } video_sync_t;

    // Status page from st_addr[7:6]
    typedef enum logic [1:0] {ST_MAIN, ST_SUB, ST_VIDEO, ST_CFG} st_page_t;

    typedef enum logic [1:0] {CL_MAIN, CL_SUB, CL_SND} rom_client_t;

endpackage

// ==== outrun_cen.sv ====
// Pixel enables in fixed phase from clk; both stay low for the first 3 cycles after reset
`timescale 1ns/1ps

module outrun_cen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    // Free-running divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 3'd1;
            // One in four
            pxl2_cen <= cnt[1:0] == 2'd3;
            // One in eight, lands on a pxl2_cen slot
            pxl_cen  <= cnt == 3'd3;
        end
    end

endmodule

// ==== outrun_vtiming.sv ====
// Video timing on pxl_cen; counters are 9 bits so totals must not exceed 512
`timescale 1ns/1ps

module outrun_vtiming #(
    parameter int H_TOTAL      = 512,
    parameter int H_ACTIVE     = 320,
    parameter int H_SYNC_START = 336,
    parameter int H_SYNC_LEN   = 32,
    parameter int V_TOTAL      = 262,
    parameter int V_ACTIVE     = 224,
    parameter int V_SYNC_START = 234,
    parameter int V_SYNC_LEN   = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pxl_cen,
    output outrun_pkg::video_sync_t sync,
    output logic [8:0]              vrender,
    output logic                    vint
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic [8:0] h_next;
    logic [8:0] v_next;
    logic       lvbl_next;

    always_comb begin
        h_next = hcnt + 9'd1;
        v_next = vcnt;
        if (hcnt == 9'(H_TOTAL - 1)) begin
            h_next = '0;
            v_next = (vcnt == 9'(V_TOTAL - 1)) ? 9'd0 : vcnt + 9'd1;
        end
        lvbl_next = v_next < 9'(V_ACTIVE);
    end

    // Line being prepared by the layers
    assign vrender = (vcnt == 9'(V_TOTAL - 1)) ? 9'd0 : vcnt + 9'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt      <= '0;
            vcnt      <= '0;
            sync.hs   <= 1'b0;
            sync.vs   <= 1'b0;
            sync.lhbl <= 1'b1;
            sync.lvbl <= 1'b1;
            vint      <= 1'b0;
        end else begin
            vint <= 1'b0;
            if (pxl_cen) begin
                hcnt      <= h_next;
                vcnt      <= v_next;
                sync.lhbl <= h_next < 9'(H_ACTIVE);
                sync.hs   <= h_next >= 9'(H_SYNC_START) &&
                             h_next < 9'(H_SYNC_START + H_SYNC_LEN);
                sync.vs   <= v_next >= 9'(V_SYNC_START) &&
                             v_next < 9'(V_SYNC_START + V_SYNC_LEN);
                sync.lvbl <= lvbl_next;
                // Start of vertical blank
                vint      <= sync.lvbl && !lvbl_next;
            end
        end
    end

endmodule

// ==== outrun_rom_slot.sv ====
// Single-word ROM cache; addresses compare on the low ADDR_W bits only
`timescale 1ns/1ps

module outrun_rom_slot #(
    parameter int                      ADDR_W      = 18,
    parameter outrun_pkg::sdram_addr_t REGION_BASE = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  outrun_pkg::rom_req_t    req,
    output outrun_pkg::rom_rsp_t    rsp,
    output logic                    need,
    output outrun_pkg::sdram_addr_t fetch_addr,
    input  logic                    fill,
    input  outrun_pkg::rom_data_t   fill_data
);

    import outrun_pkg::*;

    logic [ADDR_W-1:0] cur_addr;
    logic [ADDR_W-1:0] cached_addr;
    logic [ADDR_W-1:0] pend_addr;
    rom_data_t         cached_data;
    logic              valid;
    logic              pending;
    logic              hit;
    logic              start;

    assign cur_addr = req.addr[ADDR_W-1:0];
    assign hit      = valid && (cached_addr == cur_addr);
    // Miss with no fetch outstanding
    assign start    = req.cs && !hit && !pending;

    assign rsp.ok     = req.cs && hit;
    assign rsp.data   = cached_data;
    assign need       = pending;
    assign fetch_addr = REGION_BASE + sdram_addr_t'(pend_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= 1'b0;
            pending <= 1'b0;
        end else if (fill) begin
            valid   <= 1'b1;
            pending <= 1'b0;
        end else if (start) begin
            pending <= 1'b1;
        end
    end

    // Address held for the whole bank transaction
    always_ff @(posedge clk) begin
        if (start) begin
            pend_addr <= cur_addr;
        end
        if (fill) begin
            cached_addr <= pend_addr;
            cached_data <= fill_data;
        end
    end

endmodule

// ==== outrun_sdram_arb.sv ====
// One bank shared by main, sub and sound slots; one transaction in flight, fixed priority
`timescale 1ns/1ps

module outrun_sdram_arb #(
    parameter int                      MAIN_ADDR_W      = 18,
    parameter outrun_pkg::sdram_addr_t MAIN_REGION_BASE = '0,
    parameter int                      SUB_ADDR_W       = 17,
    parameter outrun_pkg::sdram_addr_t SUB_REGION_BASE  = '0,
    parameter int                      SND_ADDR_W       = 15,
    parameter outrun_pkg::sdram_addr_t SND_REGION_BASE  = '0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  outrun_pkg::rom_req_t   main_req,
    input  outrun_pkg::rom_req_t   sub_req,
    input  outrun_pkg::rom_req_t   snd_req,
    output outrun_pkg::rom_rsp_t   main_rsp,
    output outrun_pkg::rom_rsp_t   sub_rsp,
    output outrun_pkg::rom_rsp_t   snd_rsp,
    output outrun_pkg::sdram_req_t ba,
    input  outrun_pkg::sdram_rsp_t ba_rsp,
    output logic [7:0]             main_count,
    output logic [7:0]             sub_count
);

    import outrun_pkg::*;

    typedef enum logic [1:0] {ARB_IDLE, ARB_REQ, ARB_WAIT} arb_state_t;

    arb_state_t  state;
    rom_client_t gnt;
    logic [2:0]  need;
    logic [2:0]  fill;
    sdram_addr_t main_fa;
    sdram_addr_t sub_fa;
    sdram_addr_t snd_fa;
    logic        done;

    outrun_rom_slot #(.ADDR_W(MAIN_ADDR_W), .REGION_BASE(MAIN_REGION_BASE)) u_main (
        .clk(clk), .rst_n(rst_n), .req(main_req), .rsp(main_rsp), .need(need[CL_MAIN]),
        .fetch_addr(main_fa), .fill(fill[CL_MAIN]), .fill_data(ba_rsp.data_read)
    );

    outrun_rom_slot #(.ADDR_W(SUB_ADDR_W), .REGION_BASE(SUB_REGION_BASE)) u_sub (
        .clk(clk), .rst_n(rst_n), .req(sub_req), .rsp(sub_rsp), .need(need[CL_SUB]),
        .fetch_addr(sub_fa), .fill(fill[CL_SUB]), .fill_data(ba_rsp.data_read)
    );

    outrun_rom_slot #(.ADDR_W(SND_ADDR_W), .REGION_BASE(SND_REGION_BASE)) u_snd (
        .clk(clk), .rst_n(rst_n), .req(snd_req), .rsp(snd_rsp), .need(need[CL_SND]),
        .fetch_addr(snd_fa), .fill(fill[CL_SND]), .fill_data(ba_rsp.data_read)
    );

    // Data arrives for the granted slot only
    assign done           = (state == ARB_WAIT) && ba_rsp.rdy;
    assign fill[CL_MAIN]  = done && (gnt == CL_MAIN);
    assign fill[CL_SUB]   = done && (gnt == CL_SUB);
    assign fill[CL_SND]   = done && (gnt == CL_SND);

    always_comb begin
        ba.rd = state == ARB_REQ;
        case (gnt)
            CL_SUB:  ba.addr = sub_fa;
            CL_SND:  ba.addr = snd_fa;
            default: ba.addr = main_fa;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            gnt   <= CL_MAIN;
        end else begin
            case (state)
                ARB_IDLE: if (|need) begin
                    state <= ARB_REQ;
                    if (need[CL_MAIN]) gnt <= CL_MAIN;
                    else if (need[CL_SUB]) gnt <= CL_SUB;
                    else gnt <= CL_SND;
                end
                // rd and addr held until the bank takes them
                ARB_REQ:  if (ba_rsp.ack) state <= ARB_WAIT;
                ARB_WAIT: if (ba_rsp.rdy) state <= ARB_IDLE;
                default:  state <= ARB_IDLE;
            endcase
        end
    end

    // Completed fetches, wrapping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_count <= '0;
            sub_count  <= '0;
        end else begin
            if (fill[CL_MAIN]) main_count <= main_count + 8'd1;
            if (fill[CL_SUB]) sub_count <= sub_count + 8'd1;
        end
    end

endmodule

// ==== outrun_status.sv ====
// Status byte registered one cycle after st_addr; unlisted config indices keep the last byte
`timescale 1ns/1ps

module outrun_status (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  st_addr,
    input  logic [7:0]  main_count,
    input  logic [7:0]  sub_count,
    input  logic [8:0]  vrender,
    input  logic [31:0] dipsw,
    output logic [7:0]  st_dout
);

    import outrun_pkg::*;

    st_page_t    page;
    rom_client_t cl;
    logic [7:0]  fetch_count;

    always_comb begin
        page        = st_page_t'(st_addr[7:6]);
        // Fetch counter shown on the two CPU pages
        cl          = (page == ST_SUB) ? CL_SUB : CL_MAIN;
        fetch_count = (cl == CL_SUB) ? sub_count : main_count;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_dout <= '0;
        end else begin
            case (page)
                ST_MAIN, ST_SUB: st_dout <= fetch_count;
                ST_VIDEO:        st_dout <= vrender[7:0];
                default: begin
                    case (st_addr[3:0])
                        4'd0:    st_dout <= dipsw[7:0];
                        4'd1:    st_dout <= dipsw[15:8];
                        default: st_dout <= st_dout;
                    endcase
                end
            endcase
        end
    end

endmodule

// ==== outrun_core.sv ====
// Board core with ROM clients exposed as ports; single SDRAM bank, single clock domain
`timescale 1ns/1ps

module outrun_core (
    input  logic                    clk,
    input  logic                    rst_n,
    // CPU program fetch
    input  outrun_pkg::rom_req_t    main_req,
    input  outrun_pkg::rom_req_t    sub_req,
    input  outrun_pkg::rom_req_t    snd_req,
    output outrun_pkg::rom_rsp_t    main_rsp,
    output outrun_pkg::rom_rsp_t    sub_rsp,
    output outrun_pkg::rom_rsp_t    snd_rsp,
    // SDRAM bank
    output outrun_pkg::sdram_req_t  ba,
    input  outrun_pkg::sdram_rsp_t  ba_rsp,
    // Video
    output outrun_pkg::video_sync_t sync,
    output logic [8:0]              vrender,
    output logic                    vint,
    output logic                    pxl_cen,
    output logic                    pxl2_cen,
    // Status dump
    input  logic [31:0]             dipsw,
    input  logic [7:0]              st_addr,
    output logic [7:0]              st_dout
);

    logic [7:0] main_count;
    logic [7:0] sub_count;

    outrun_cen u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    outrun_vtiming #(
        .H_TOTAL      ( 512 ),
        .H_ACTIVE     ( 320 ),
        .H_SYNC_START ( 336 ),
        .H_SYNC_LEN   ( 32  ),
        .V_TOTAL      ( 262 ),
        .V_ACTIVE     ( 224 ),
        .V_SYNC_START ( 234 ),
        .V_SYNC_LEN   ( 3   )
    ) u_vtiming (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .sync    ( sync    ),
        .vrender ( vrender ),
        .vint    ( vint    )
    );

    // ROM regions inside the bank
    outrun_sdram_arb #(
        .MAIN_ADDR_W      ( 18           ),
        .MAIN_REGION_BASE ( 22'h000000   ),
        .SUB_ADDR_W       ( 17           ),
        .SUB_REGION_BASE  ( 22'h040000   ),
        .SND_ADDR_W       ( 15           ),
        .SND_REGION_BASE  ( 22'h060000   )
    ) u_arb (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .main_req   ( main_req   ),
        .sub_req    ( sub_req    ),
        .snd_req    ( snd_req    ),
        .main_rsp   ( main_rsp   ),
        .sub_rsp    ( sub_rsp    ),
        .snd_rsp    ( snd_rsp    ),
        .ba         ( ba         ),
        .ba_rsp     ( ba_rsp     ),
        .main_count ( main_count ),
        .sub_count  ( sub_count  )
    );

    outrun_status u_status (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .st_addr    ( st_addr    ),
        .main_count ( main_count ),
        .sub_count  ( sub_count  ),
        .vrender    ( vrender    ),
        .dipsw      ( dipsw      ),
        .st_dout    ( st_dout    )
    );

endmodule

// ==== outrun_chk.sv ====
// Bound into outrun_core; reference counts assume its 512x262 timing and its three ROM regions
`timescale 1ns/1ps

module outrun_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    pxl_cen,
    input logic                    pxl2_cen,
    input logic                    vint,
    input logic [8:0]              vrender,
    input outrun_pkg::video_sync_t sync,
    input outrun_pkg::rom_req_t    main_req,
    input outrun_pkg::rom_req_t    sub_req,
    input outrun_pkg::rom_req_t    snd_req,
    input outrun_pkg::rom_rsp_t    main_rsp,
    input outrun_pkg::rom_rsp_t    sub_rsp,
    input outrun_pkg::rom_rsp_t    snd_rsp,
    input outrun_pkg::sdram_req_t  ba,
    input outrun_pkg::sdram_rsp_t  ba_rsp
);

    import outrun_pkg::*;

    int unsigned fails = 0;
    logic [3:0]  since2;
    logic [3:0]  since1;
    logic        seen2;
    logic        seen1;
    logic [8:0]  hpos;
    logic [8:0]  vpos;

    // Word the bank holds at a given address
    function automatic rom_data_t bank_word(input sdram_addr_t a);
        return a[15:0] ^ 16'ha5c3;
    endfunction

    // Cycles since each enable, and reference pixel and line position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since2 <= '0;
            since1 <= '0;
            seen2  <= 1'b0;
            seen1  <= 1'b0;
            hpos   <= '0;
            vpos   <= '0;
        end else begin
            since2 <= pxl2_cen ? 4'd0 : since2 + 4'd1;
            since1 <= pxl_cen ? 4'd0 : since1 + 4'd1;
            seen2  <= seen2 | pxl2_cen;
            seen1  <= seen1 | pxl_cen;
            if (pxl_cen) begin
                hpos <= (hpos == 9'd511) ? 9'd0 : hpos + 9'd1;
                if (hpos == 9'd511) begin
                    vpos <= (vpos == 9'd261) ? 9'd0 : vpos + 9'd1;
                end
            end
        end
    end

    a_cen: assert property (@(posedge clk) disable iff (!rst_n)
        (!pxl_cen || pxl2_cen) && (!(pxl2_cen && seen2) || since2 == 4'd3) &&
        (!(pxl_cen && seen1) || since1 == 4'd7))
        else begin
            fails++;
            $error("pixel enables out of period or not paired");
        end

    // Blanking and sync windows of the current pixel and line
    a_video: assert property (@(posedge clk) disable iff (!rst_n)
        (sync.lhbl == (hpos < 9'd320)) && (sync.hs == (hpos >= 9'd336 && hpos < 9'd368)) &&
        (sync.lvbl == (vpos < 9'd224)) && (sync.vs == (vpos >= 9'd234 && vpos < 9'd237)))
        else begin
            fails++;
            $error("video sync or blanking outside its window");
        end

    a_vint: assert property (@(posedge clk) disable iff (!rst_n) vint == $fell(sync.lvbl))
        else begin
            fails++;
            $error("vint not aligned with the fall of lvbl");
        end

    // Render line is one ahead of the counted line, modulo the frame
    a_vrender: assert property (@(posedge clk) disable iff (!rst_n)
        vrender == 9'((32'(vpos) + 32'd1) % 32'd262))
        else begin
            fails++;
            $error("vrender is not one line ahead of the counted line");
        end

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        (!main_rsp.ok || main_rsp.data == bank_word(22'(main_req.addr[17:0]))) &&
        (!sub_rsp.ok || sub_rsp.data == bank_word(22'h040000 + 22'(sub_req.addr[16:0]))) &&
        (!snd_rsp.ok || snd_rsp.data == bank_word(22'h060000 + 22'(snd_req.addr[14:0]))))
        else begin
            fails++;
            $error("client data does not match the addressed ROM word");
        end

    // Request held until the bank takes it
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ba.rd && !ba_rsp.ack |=> ba.rd && $stable(ba.addr))
        else begin
            fails++;
            $error("bank request changed before ack");
        end

endmodule

bind outrun_core outrun_chk chk (.*);

// ==== outrun_tb.sv ====
// Runs about three video frames before the ROM tests; bank delays come from a fixed seed
`timescale 1ns/1ps

module outrun_tb;

    import outrun_pkg::*;

    logic        clk;
    logic        rst_n;
    rom_req_t    main_req;
    rom_req_t    sub_req;
    rom_req_t    snd_req;
    rom_rsp_t    main_rsp;
    rom_rsp_t    sub_rsp;
    rom_rsp_t    snd_rsp;
    sdram_req_t  ba;
    sdram_rsp_t  ba_rsp;
    video_sync_t sync;
    logic [8:0]  vrender;
    logic        vint;
    logic        pxl_cen;
    logic        pxl2_cen;
    logic [31:0] dipsw;
    logic [7:0]  st_addr;
    logic [7:0]  st_dout;

    integer      seed = 32'he059d8e9;
    int unsigned errors = 0;
    int unsigned tests_run = 0;
    int unsigned tests_failed = 0;
    int unsigned main_fetches = 0;
    int unsigned sub_fetches = 0;
    sdram_addr_t bank_log[$];

    outrun_core dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Bank model answers ack 1 to 3 cycles after rd and rdy 1 to 4 cycles after ack
    initial begin
        int unsigned delay;
        sdram_addr_t addr;
        ba_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && ba.rd) begin
                addr  = ba.addr;
                delay = {$random(seed)} % 3;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                ba_rsp.ack = 1'b1;
                bank_log.push_back(addr);
                @(posedge clk);
                #1;
                ba_rsp.ack = 1'b0;
                delay      = {$random(seed)} % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                ba_rsp.rdy       = 1'b1;
                ba_rsp.data_read = addr[15:0] ^ 16'ha5c3;
                if (addr < 22'h040000) begin
                    main_fetches++;
                end else if (addr < 22'h060000) begin
                    sub_fetches++;
                end
                @(posedge clk);
                #1;
                ba_rsp.rdy = 1'b0;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int unsigned all_errors();
        return errors + dut.chk.fails;
    endfunction

    function automatic logic ok_of(input rom_client_t cl);
        case (cl)
            CL_SUB:  return sub_rsp.ok;
            CL_SND:  return snd_rsp.ok;
            default: return main_rsp.ok;
        endcase
    endfunction

    task automatic drive_req(input rom_client_t cl, input logic cs, input sdram_addr_t addr);
        case (cl)
            CL_SUB:  sub_req = {cs, addr};
            CL_SND:  snd_req = {cs, addr};
            default: main_req = {cs, addr};
        endcase
    endtask

    task automatic expect_eq(input string what, input int unsigned got, input int unsigned exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // Poll after the combinational ok path has settled
    task automatic wait_ok(input rom_client_t cl, input string what);
        int unsigned n;
        n = 0;
        #1;
        while (!ok_of(cl) && n < 100) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ok_of(cl)) begin
            $display("timeout: %s got no ok within %0d cycles", what, n);
            errors++;
        end
    endtask

    task automatic check_status(input logic [7:0] addr, input logic [7:0] exp, input string what);
        st_addr = addr;
        next_cycle();
        expect_eq(what, 32'(st_dout), 32'(exp));
    endtask

    // Counts from now up to and including the next vint
    task automatic measure_frame(output int unsigned enables, output int unsigned blank,
                                 output int unsigned lines);
        int unsigned n;
        logic        hs_prev;
        enables = 0;
        blank   = 0;
        lines   = 0;
        n       = 0;
        hs_prev = sync.hs;
        do begin
            next_cycle();
            n++;
            if (pxl_cen) enables++;
            if (pxl_cen && !sync.lhbl) blank++;
            if (sync.hs && !hs_prev) lines++;
            hs_prev = sync.hs;
        end while (!vint && n < 1200000);
        if (!vint) begin
            $display("timeout: no vint within %0d cycles", n);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int unsigned errs_at_start);
        tests_run++;
        if (all_errors() != errs_at_start) begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int unsigned start_errs;
        int unsigned en;
        int unsigned bl;
        int unsigned ln;
        int unsigned log_len;
        int unsigned count_before;
        sdram_addr_t a;
        rom_client_t cl;
        rst_n    = 1'b0;
        main_req = '0;
        sub_req  = '0;
        snd_req  = '0;
        dipsw    = 32'h5a3c_9e71;
        st_addr  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // First partial frame only aligns to vint
        start_errs = all_errors();
        measure_frame(en, bl, ln);
        for (int f = 0; f < 2; f++) begin
            measure_frame(en, bl, ln);
            expect_eq("pixel enables per frame", en, 32'd134144);
            expect_eq("blanked enables per frame", bl, 32'd50304);
            expect_eq("lines per frame", ln, 32'd262);
        end
        end_test("video_timing", start_errs);

        // Caches are empty, so all three miss together
        start_errs = all_errors();
        log_len = bank_log.size();
        next_cycle();
        main_req = {1'b1, 22'h012345};
        sub_req  = {1'b1, 22'h00abcd};
        snd_req  = {1'b1, 22'h001f2e};
        wait_ok(CL_MAIN, "main fetch");
        wait_ok(CL_SUB, "sub fetch");
        wait_ok(CL_SND, "sound fetch");
        next_cycle();
        main_req.cs = 1'b0;
        sub_req.cs  = 1'b0;
        snd_req.cs  = 1'b0;
        if (bank_log.size() != log_len + 3) begin
            $display("mismatch at %0t: bank saw %0d reads for three misses",
                     $time, bank_log.size() - log_len);
            errors++;
        end else begin
            expect_eq("first bank address", 32'(bank_log[log_len]), 32'h012345);
            expect_eq("second bank address", 32'(bank_log[log_len + 1]), 32'h04abcd);
            expect_eq("third bank address", 32'(bank_log[log_len + 2]), 32'h061f2e);
        end
        end_test("bank_order", start_errs);

        start_errs = all_errors();
        for (int i = 0; i < 12; i++) begin
            a  = sdram_addr_t'({$random(seed)}) & 22'h007fff;
            cl = rom_client_t'(2'(i % 3));
            next_cycle();
            drive_req(cl, 1'b1, a);
            wait_ok(cl, "random read");
            next_cycle();
            drive_req(cl, 1'b0, a);
        end
        end_test("client_data", start_errs);

        start_errs = all_errors();
        next_cycle();
        drive_req(CL_MAIN, 1'b1, 22'h002468);
        wait_ok(CL_MAIN, "main first read");
        next_cycle();
        check_status(8'h00, 8'(main_fetches), "main count before repeat");
        log_len      = bank_log.size();
        count_before = main_fetches;
        drive_req(CL_MAIN, 1'b0, 22'h002468);
        next_cycle();
        // A hit answers in the same cycle
        drive_req(CL_MAIN, 1'b1, 22'h002468);
        for (int i = 0; i < 16; i++) begin
            #1;
            if (!main_rsp.ok) begin
                $display("mismatch at %0t: main ok low on a cached address", $time);
                errors++;
            end
            next_cycle();
        end
        drive_req(CL_MAIN, 1'b0, 22'h002468);
        expect_eq("bank reads on repeat", 32'(bank_log.size()), log_len);
        check_status(8'h00, 8'(count_before), "main count after repeat");
        end_test("repeat_read", start_errs);

        start_errs = all_errors();
        check_status(8'h00, 8'(main_fetches), "main fetch count");
        check_status(8'h40, 8'(sub_fetches), "sub fetch count");
        check_status(8'hc1, dipsw[15:8], "dipsw byte 1");
        check_status(8'hc0, dipsw[7:0], "dipsw byte 0");
        check_status(8'hc5, dipsw[7:0], "config index 5");
        end_test("status", start_errs);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, all_errors());
        if (tests_failed == 0 && all_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
outrun_pkg.sv
outrun_cen.sv
outrun_vtiming.sv
outrun_rom_slot.sv
outrun_sdram_arb.sv
outrun_status.sv
outrun_core.sv
outrun_chk.sv
outrun_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f files.f --top-module outrun_tb -o outrun_sim &&
./obj_dir/outrun_sim | grep "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
